// File: grouper_top.f
grouper_pkg.sv
word_ram.sv
matcher.sv
grouper.sv
grouper_top.sv
tb_grouper.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the grouper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f grouper_top.f --top-module tb_grouper -o sim_grouper
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_grouper)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" <<< "$output"; then
    exit 0
fi
exit 1

// File: tb_grouper.sv
`timescale 1ns/1ps

module tb_grouper
    import grouper_pkg::*;
();

    localparam int reset_cycles = 16;
    localparam int pass_count   = 7;                // passes run by tests 2 to 5.
    localparam int run_cycles   = 400;              // load, pass and read back of one run.
    localparam int pass_limit   = 300;
    localparam int watchdog_time = (reset_cycles + (pass_count + 1) * run_cycles) * 10;

    logic              clk;
    logic              rst_n;
    host_req_t         host;
    logic [data_w-1:0] host_rdata;
    logic              start;
    logic              done;

    logic [data_w-1:0] in_arr  [mem_depth];
    logic [data_w-1:0] voc_arr [mem_depth];
    logic [data_w-1:0] out_arr [mem_depth];
    logic [data_w-1:0] exp_in  [mem_depth];
    logic [data_w-1:0] exp_out [mem_depth];
    logic [data_w-1:0] buf_tok [4];
    int                voc_start [3];
    int                voc_len   [3];
    int                gen_pos;
    int                buf_len;
    logic [31:0]       lcg_state = 32'h66853986;
    int                errors;
    int                checks;
    int                test_errors;
    int                done_rises;
    logic              done_q;

    grouper_top i_grouper_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .host       (host),
        .host_rdata (host_rdata),
        .start      (start),
        .done       (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        done_q <= done;
        if (done && !done_q) begin
            done_rises = done_rises + 1;
        end
    end

    // an accepted start always pulls done low in the next cycle.
    a_done_falls: assert property (@(posedge clk) disable iff (!rst_n) (start && done) |=> !done)
        else begin
            $display("done stayed high after a start was accepted");
            errors++;
        end

    initial begin
        #(watchdog_time);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] rand_tok();
        logic [31:0] r;
        r = lcg_next();
        return 8'(r[17:16]) + 8'd1;                 // tokens 1 to 4 only.
    endfunction

    task automatic host_write(input mem_sel_e sel, input int a, input logic [7:0] d);
        @(posedge clk);
        #1;
        host.sel        = sel;
        host.req.addr   = 4'(a);
        host.req.wdata  = d;
        host.req.we     = 1'b1;
        host.stb        = 1'b1;
    endtask

    task automatic host_idle();
        @(posedge clk);
        #1;
        host.stb    = 1'b0;
        host.req.we = 1'b0;
    endtask

    task automatic read_check(input mem_sel_e sel, input int a, input logic [7:0] e,
                              input string name);
        @(posedge clk);
        #1;
        host.sel       = sel;
        host.req.addr  = 4'(a);
        host.req.we    = 1'b0;
        host.stb       = 1'b1;
        @(negedge clk);
        checks++;
        assert (host_rdata == e) else begin
            $display("ERROR host_rdata %s[%0d] got %h expected %h", name, a, host_rdata, e);
            errors++;
        end
    endtask

    task automatic fill_arrays();
        for (int a = 0; a < mem_depth; a++) begin
            in_arr[a]  = 8'h80 | 8'(a);
            voc_arr[a] = 8'h00;
            out_arr[a] = 8'he0 | 8'(a);
        end
    endtask

    task automatic load_all();
        for (int a = 0; a < mem_depth; a++) begin
            host_write(sel_input, a, in_arr[a]);
            host_write(sel_vocab, a, voc_arr[a]);
            host_write(sel_output, a, out_arr[a]);
        end
        host_idle();
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < pass_limit) begin
            @(negedge clk);
            n++;
        end
        assert (done) else begin
            $display("done did not rise within %0d cycles", pass_limit);
            errors++;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [7:0] in_tok(input int p);
        return (p >= mem_depth - 1) ? 8'h00 : in_arr[p];    // last address closes a word.
    endfunction

    function automatic logic [7:0] voc_tok(input int p);
        return (p >= mem_depth - 1) ? 8'h00 : voc_arr[p];
    endfunction

    // whole word against whole vocabulary word, so a prefix does not count.
    function automatic bit in_vocab(input int base);
        int v;
        int k;
        v = 0;
        while (v < mem_depth && voc_tok(v) != 8'h00) begin
            k = 0;
            while (in_tok(base + k) == voc_tok(v + k) && in_tok(base + k) != 8'h00) k++;
            if (in_tok(base + k) == 8'h00 && voc_tok(v + k) == 8'h00) return 1'b1;
            while (v < mem_depth && voc_tok(v) != 8'h00) v++;
            v++;
        end
        return 1'b0;
    endfunction

    task automatic compute_expected();
        int rd;
        int wr;
        int op;
        bit hit;
        rd = 0;
        wr = 0;
        op = 0;
        exp_in  = in_arr;
        exp_out = out_arr;
        while (rd < mem_depth && in_tok(rd) != 8'h00) begin
            hit = in_vocab(rd);
            while (in_tok(rd) != 8'h00) begin
                if (hit) begin
                    exp_out[op] = in_tok(rd);
                    op++;
                end else begin
                    exp_in[wr] = in_tok(rd);
                    wr++;
                end
                rd++;
            end
            if (hit) begin
                exp_out[op] = 8'h00;
                op++;
            end else begin
                exp_in[wr] = 8'h00;
                wr++;
            end
            rd++;
        end
        if (wr < mem_depth) exp_in[wr] = 8'h00;         // extra zero ends each list.
        if (op < mem_depth) exp_out[op] = 8'h00;
    endtask

    task automatic check_results();
        for (int a = 0; a < mem_depth; a++) read_check(sel_input, a, exp_in[a], "input");
        for (int a = 0; a < mem_depth; a++) read_check(sel_output, a, exp_out[a], "output");
        host_idle();
    endtask

    task automatic run_and_check();
        compute_expected();
        load_all();
        pulse_start();
        wait_done();
        check_results();
    endtask

    task automatic build_word();
        logic [31:0] r;
        int w;
        r = lcg_next();
        w = int'(r[9:8]) % 3;
        buf_len = 0;
        if (r[1:0] == 2'd0) begin
            buf_len = 1 + int'(r[5:4]) % 3;
            for (int k = 0; k < buf_len; k++) buf_tok[k] = rand_tok();
        end else begin
            buf_len = voc_len[w];
            for (int k = 0; k < buf_len; k++) buf_tok[k] = voc_arr[voc_start[w] + k];
            if (r[1:0] == 2'd3) begin
                if (buf_len > 1) begin
                    buf_len--;                          // near miss by prefix.
                end else begin
                    buf_tok[1] = rand_tok();
                    buf_len = 2;
                end
            end
        end
    endtask

    task automatic gen_random(input bit full);
        bit more;
        fill_arrays();
        gen_pos = 0;
        for (int w = 0; w < 3; w++) begin
            voc_start[w] = gen_pos;
            voc_len[w]   = 1 + int'(lcg_next() >> 20) % 3;
            for (int k = 0; k < voc_len[w]; k++) begin
                voc_arr[gen_pos] = rand_tok();
                gen_pos++;
            end
            voc_arr[gen_pos] = 8'h00;
            gen_pos++;
        end
        gen_pos = 0;
        more = 1'b1;
        while (more) begin
            build_word();
            if (!full && gen_pos + buf_len + 1 > mem_depth - 1) begin
                in_arr[gen_pos] = 8'h00;                // empty word ends the list.
                more = 1'b0;
            end else begin
                for (int k = 0; k < buf_len && gen_pos < mem_depth; k++) begin
                    in_arr[gen_pos] = buf_tok[k];
                    gen_pos++;
                end
                if (gen_pos < mem_depth) begin
                    in_arr[gen_pos] = 8'h00;
                    gen_pos++;
                end
                more = (gen_pos < mem_depth);
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int rises;
        host        = '0;
        start       = 1'b0;
        rst_n       = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        done_rises  = 0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        checks++;
        assert (!done) else begin
            $display("ERROR done got %h expected %h", done, 1'b0);
            errors++;
        end
        host_write(sel_input, 3, 8'h5a);
        host_write(sel_vocab, 3, 8'ha5);
        host_write(sel_output, 3, 8'h3c);
        host_idle();
        read_check(sel_input, 3, 8'h5a, "input");
        read_check(sel_vocab, 3, 8'ha5, "vocab");
        read_check(sel_output, 3, 8'h3c, "output");
        host_idle();
        end_test(1, "host access");

        fill_arrays();
        voc_arr[0:6] = '{8'd1, 8'd2, 8'd0, 8'd3, 8'd0, 8'd4, 8'd1};
        voc_arr[7:8] = '{8'd2, 8'd0};
        in_arr[0:6]  = '{8'd3, 8'd0, 8'd1, 8'd2, 8'd0, 8'd4, 8'd1};
        in_arr[7:11] = '{8'd2, 8'd0, 8'd3, 8'd0, 8'd0};
        run_and_check();
        end_test(2, "all words known");

        fill_arrays();
        voc_arr[0:6] = '{8'd1, 8'd2, 8'd3, 8'd0, 8'd4, 8'd4, 8'd0};
        in_arr[0:6]  = '{8'd1, 8'd2, 8'd0, 8'd3, 8'd0, 8'd4, 8'd0};
        in_arr[7:9]  = '{8'd2, 8'd1, 8'd0};
        in_arr[10]   = 8'd0;
        run_and_check();
        end_test(3, "no word known");

        for (int run = 0; run < 4; run++) begin
            gen_random(run == 3);                       // the last list fills all addresses.
            run_and_check();
        end
        end_test(4, "random lists");

        // disturbed pass over the list of test 2.
        fill_arrays();
        voc_arr[0:6] = '{8'd1, 8'd2, 8'd0, 8'd3, 8'd0, 8'd4, 8'd1};
        voc_arr[7:8] = '{8'd2, 8'd0};
        in_arr[0:6]  = '{8'd3, 8'd0, 8'd1, 8'd2, 8'd0, 8'd4, 8'd1};
        in_arr[7:11] = '{8'd2, 8'd0, 8'd3, 8'd0, 8'd0};
        compute_expected();
        load_all();
        rises = done_rises;
        pulse_start();
        repeat (3) @(posedge clk);
        pulse_start();
        // these addresses are never written by the pass itself.
        host_write(sel_input, mem_depth - 1, 8'hff);
        host_write(sel_vocab, 0, 8'hff);
        host_write(sel_output, mem_depth - 1, 8'hff);
        host_idle();
        wait_done();
        check_results();
        checks++;
        assert (done_rises == rises + 1) else begin
            $display("ERROR done_rises got %h expected %h", done_rises, rises + 1);
            errors++;
        end
        end_test(5, "ignored requests");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: grouper_top.sv
`timescale 1ns/1ps

module grouper_top
    import grouper_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  host_req_t         host,
    output logic [data_w-1:0] host_rdata,
    input  logic              start,
    output logic              done
);

    logic              busy;
    logic              host_wr;
    mem_req_t          in_req;
    mem_req_t          out_req;
    mem_req_t          in_mem_req;
    mem_req_t          voc_mem_req;
    mem_req_t          out_mem_req;
    logic [data_w-1:0] in_rdata;
    logic [data_w-1:0] voc_rdata;
    logic [data_w-1:0] out_rdata;
    logic              m_start;
    logic              m_done;
    logic              m_found;
    logic [addr_w-1:0] m_base;
    logic [addr_w-1:0] m_in_addr;
    logic [addr_w-1:0] voc_addr;

    assign host_wr = host.stb && host.req.we && !busy;      // host is locked out during a pass.

    //////////////////////////////
    // memory ownership
    //////////////////////////////

    always_comb begin
        in_mem_req        = host.req;
        in_mem_req.we     = host_wr && (host.sel == sel_input);
        voc_mem_req       = host.req;
        voc_mem_req.we    = host_wr && (host.sel == sel_vocab);
        out_mem_req       = host.req;
        out_mem_req.we    = host_wr && (host.sel == sel_output);
        if (busy) begin
            in_mem_req       = in_req;
            voc_mem_req.addr = voc_addr;    // vocabulary is only read by the matcher.
            out_mem_req      = out_req;
        end
    end

    always_comb begin
        case (host.sel)
            sel_input: host_rdata = in_rdata;
            sel_vocab: host_rdata = voc_rdata;
            default:   host_rdata = out_rdata;
        endcase
    end

    word_ram i_input_ram  (.clk(clk), .req(in_mem_req),  .rdata(in_rdata));
    word_ram i_vocab_ram  (.clk(clk), .req(voc_mem_req), .rdata(voc_rdata));
    word_ram i_output_ram (.clk(clk), .req(out_mem_req), .rdata(out_rdata));

    matcher i_matcher (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (m_start),
        .base     (m_base),
        .in_addr  (m_in_addr),
        .in_data  (in_rdata),
        .voc_addr (voc_addr),
        .voc_data (voc_rdata),
        .done     (m_done),
        .found    (m_found)
    );

    grouper i_grouper (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .in_req    (in_req),
        .in_rdata  (in_rdata),
        .out_req   (out_req),
        .m_start   (m_start),
        .m_base    (m_base),
        .m_in_addr (m_in_addr),
        .m_done    (m_done),
        .m_found   (m_found)
    );

endmodule

// File: grouper.sv
`timescale 1ns/1ps

module grouper
    import grouper_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output mem_req_t          in_req,
    input  logic [data_w-1:0] in_rdata,
    output mem_req_t          out_req,
    output logic              m_start,
    output logic [addr_w-1:0] m_base,
    input  logic [addr_w-1:0] m_in_addr,
    input  logic              m_done,
    input  logic              m_found
);

    group_state_e      state;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   wr_ptr;          // top bit set means the kept list is full.
    logic [addr_w:0]   out_ptr;         // top bit set means the output list is full.
    logic [data_w-1:0] tok;
    logic [data_w-1:0] rd_tok;

    // valid in the states that address the input memory with rd_ptr.
    assign rd_tok = (rd_ptr == addr_last) ? '0 : in_rdata;

    assign busy    = (state != g_idle);
    assign m_base  = rd_ptr;
    assign m_start = (state == g_advance) && (rd_tok != '0);

    //////////////////////////////
    // memory requests
    //////////////////////////////

    always_comb begin
        in_req.addr   = rd_ptr;
        in_req.wdata  = '0;
        in_req.we     = 1'b0;
        out_req.addr  = out_ptr[addr_w-1:0];
        out_req.wdata = '0;
        out_req.we    = 1'b0;
        case (state)
            g_match: in_req.addr = m_in_addr;   // the matcher reads while it runs.
            g_keep_step: begin
                in_req.addr  = wr_ptr[addr_w-1:0];
                in_req.wdata = tok;
                in_req.we    = 1'b1;
            end
            g_move_copy: begin
                out_req.wdata = rd_tok;
                out_req.we    = (rd_tok != '0);
            end
            g_move_term: out_req.we = 1'b1;     // closing zero of the moved word.
            g_finish_in: begin
                in_req.addr = wr_ptr[addr_w-1:0];
                in_req.we   = !wr_ptr[addr_w];
            end
            g_finish_out: out_req.we = !out_ptr[addr_w];
            default: ;
        endcase
    end

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= g_idle;
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            out_ptr <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                g_idle: begin
                    if (start) begin
                        rd_ptr  <= '0;
                        wr_ptr  <= '0;
                        out_ptr <= '0;
                        done    <= 1'b0;
                        state   <= g_advance;
                    end
                end
                g_advance: begin
                    if (rd_tok == '0) begin
                        state <= g_finish_in;       // empty word, the list ends.
                    end else begin
                        state <= g_match;
                    end
                end
                g_match: begin
                    if (m_done) begin
                        state <= m_found ? g_move_copy : g_keep_copy;
                    end
                end
                g_keep_copy: state <= g_keep_step;
                g_keep_step: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (tok == '0) begin
                        state <= g_skip;
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= g_keep_copy;
                    end
                end
                g_move_copy: begin
                    if (rd_tok != '0) begin
                        rd_ptr  <= rd_ptr + 1'b1;
                        out_ptr <= out_ptr + 1'b1;
                    end else begin
                        state <= g_move_term;
                    end
                end
                g_move_term: begin
                    out_ptr <= out_ptr + 1'b1;
                    state   <= g_skip;
                end
                g_skip: begin
                    // rd_ptr sits on the word's terminator here.
                    if (rd_ptr == addr_last) begin
                        state <= g_finish_in;
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= g_advance;
                    end
                end
                g_finish_in: state <= g_finish_out;
                g_finish_out: state <= g_done;
                g_done: begin
                    done  <= 1'b1;
                    state <= g_idle;
                end
                default: state <= g_idle;
            endcase
        end
    end

    // token held between the read and the write of a kept word.
    always_ff @(posedge clk) begin
        if (state == g_keep_copy) begin
            tok <= rd_tok;
        end
    end

    a_wr_behind_rd: assert property (@(posedge clk) disable iff (!rst_n)
        state == g_keep_step |-> wr_ptr <= {1'b0, rd_ptr});

endmodule

// File: matcher.sv
`timescale 1ns/1ps

module matcher
    import grouper_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [addr_w-1:0] base,
    output logic [addr_w-1:0] in_addr,
    input  logic [data_w-1:0] in_data,
    output logic [addr_w-1:0] voc_addr,
    input  logic [data_w-1:0] voc_data,
    output logic              done,
    output logic              found
);

    match_state_e      state;
    logic [addr_w-1:0] in_ptr;
    logic [addr_w-1:0] voc_ptr;
    logic [data_w-1:0] in_tok;
    logic              voc_last;

    // the input word is cut at the last address, the same way the grouper sees it.
    assign in_tok   = (in_ptr == addr_last) ? '0 : in_data;
    assign voc_last = (voc_ptr == addr_last);

    assign in_addr  = in_ptr;
    assign voc_addr = voc_ptr;
    assign done     = (state == m_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= m_idle;
            in_ptr  <= '0;
            voc_ptr <= '0;
            found   <= 1'b0;
        end else begin
            case (state)
                m_idle: begin
                    if (start) begin
                        in_ptr  <= base;
                        voc_ptr <= '0;
                        found   <= 1'b0;
                        state   <= m_next;
                    end
                end
                m_next: begin
                    if (voc_data == '0) begin
                        state <= m_done;            // empty word ends the vocabulary.
                    end else begin
                        state <= m_cmp;
                    end
                end
                m_cmp: begin
                    if (in_tok == voc_data) begin
                        if (in_tok == '0) begin
                            found <= 1'b1;          // both words ended together.
                            state <= m_done;
                        end else if (voc_last) begin
                            state <= m_done;
                        end else begin
                            in_ptr  <= in_ptr + 1'b1;
                            voc_ptr <= voc_ptr + 1'b1;
                        end
                    end else if (voc_data == '0) begin
                        // the vocabulary word was only a prefix, so try the next one.
                        if (voc_last) begin
                            state <= m_done;
                        end else begin
                            voc_ptr <= voc_ptr + 1'b1;
                            in_ptr  <= base;
                            state   <= m_next;
                        end
                    end else if (voc_last) begin
                        state <= m_done;
                    end else begin
                        voc_ptr <= voc_ptr + 1'b1;
                        state   <= m_skip;
                    end
                end
                m_skip: begin
                    if (voc_last) begin
                        state <= m_done;
                    end else if (voc_data == '0) begin
                        voc_ptr <= voc_ptr + 1'b1;
                        in_ptr  <= base;
                        state   <= m_next;
                    end else begin
                        voc_ptr <= voc_ptr + 1'b1;
                    end
                end
                m_done: state <= m_idle;
                default: state <= m_idle;
            endcase
        end
    end

    // the grouper must wait for done before it asks again.
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> state == m_idle);

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram
    import grouper_pkg::*;
(
    input  logic              clk,
    input  mem_req_t          req,
    output logic [data_w-1:0] rdata
);

    logic [data_w-1:0] mem [mem_depth];

    // writes land on the clock edge.
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

    assign rdata = mem[req.addr];       // read is combinational.

endmodule

// File: grouper_pkg.sv
package grouper_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int addr_w = 4;
    localparam int data_w = 8;
    localparam int mem_depth = 1 << addr_w;

    // highest address of every memory; a token stored here always closes a word.
    localparam logic [addr_w-1:0] addr_last = addr_w'(mem_depth - 1);

    //////////////////////////////
    // access types
    //////////////////////////////

    // one access to a token memory.
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              we;
    } mem_req_t;

    typedef enum logic [1:0] {
        sel_input,
        sel_vocab,
        sel_output
    } mem_sel_e;

    // host access, qualified by stb.
    typedef struct packed {
        mem_sel_e sel;
        mem_req_t req;
        logic     stb;
    } host_req_t;

    //////////////////////////////
    // state encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        m_idle,
        m_cmp,                      // compare one token pair.
        m_skip,                     // run to the end of a vocabulary word.
        m_next,                     // look at the start of a vocabulary word.
        m_done
    } match_state_e;

    typedef enum logic [3:0] {
        g_idle,
        g_match,
        g_keep_copy,
        g_keep_step,
        g_move_copy,
        g_move_term,
        g_skip,
        g_advance,
        g_finish_in,
        g_finish_out,
        g_done
    } group_state_e;

endpackage
